/* turfctl_reg_pkg.sv */
`default_nettype none

package turfctl_reg_pkg;

    // Wishbone geometry
    localparam int ADR_W = 6;
    localparam int DAT_W = 32;
    localparam int SEL_W = 4;

    // Decoded register addresses
    localparam logic [ADR_W-1:0] ADR_CTRL   = 6'h00;
    localparam logic [ADR_W-1:0] ADR_IDELAY = 6'h04;
    localparam logic [ADR_W-1:0] ADR_CIN    = 6'h0C;

    // Control/status register at 0x00
    localparam int BIT_MMCM_RST    = 0;
    localparam int BIT_MMCM_LOCKED = 1;
    localparam int BIT_ISERDES_RST = 2;
    localparam int BIT_CIN_RST     = 3;
    localparam int BIT_LOCK_EN     = 8;
    localparam int BIT_CIN_LOCKED  = 9;
    localparam int BIT_COUT_TRAIN  = 10;
    // Phase target occupies PS_W bits from here
    localparam int PS_LSB          = 16;
    localparam int BIT_PS_BUSY     = 31;

    // Wishbone access FSM
    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_RX,
        WAIT_SYS
    } wb_state_t;

endpackage

`default_nettype wire

/* turfctl_phy_pkg.sv */
`default_nettype none

package turfctl_phy_pkg;

    // RXCLK MMCM phase, counted in fine steps
    localparam int PS_W = 9;

    // 56 fine steps per VCO period, RXCLK is 8x
    localparam logic [PS_W-1:0] PS_STEPS_DEFAULT = 9'd448;

    // IDELAY tap count and CIN parallel word
    localparam int IDELAY_W = 6;
    localparam int CIN_W    = 32;

    typedef logic [IDELAY_W-1:0] idelay_t;
    typedef logic [CIN_W-1:0]    cin_word_t;

endpackage

`default_nettype wire

/* flag_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module flag_sync (
    input  logic clk_a_i,
    input  logic rst_a_i,
    input  logic flag_a_i,
    input  logic clk_b_i,
    input  logic rst_b_i,
    output logic flag_b_o
);

    logic       toggle_a_q;
    logic [2:0] toggle_b_q;

    // Each source pulse flips the level
    always_ff @(posedge clk_a_i) begin
        if (rst_a_i) begin
            toggle_a_q <= 1'b0;
        end else if (flag_a_i) begin
            toggle_a_q <= ~toggle_a_q;
        end
    end

    // Two resync stages, the third one only for edge detect
    always_ff @(posedge clk_b_i) begin
        if (rst_b_i) begin
            toggle_b_q <= '0;
        end else begin
            toggle_b_q <= {toggle_b_q[1:0], toggle_a_q};
        end
    end

    assign flag_b_o = toggle_b_q[2] ^ toggle_b_q[1];

    // Closely spaced pulses cancel out in a slow destination
    a_flag_spacing : assert property (
        @(posedge clk_a_i) disable iff (rst_a_i) flag_a_i |=> !flag_a_i [*3]
    );

endmodule

`default_nettype wire

/* domain_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface domain_req_if;

    // Level request, address/we/data held steady until ack
    logic                              req;
    logic [turfctl_reg_pkg::ADR_W-1:0] adr;
    logic                              we;
    logic [turfctl_reg_pkg::DAT_W-1:0] wdat;

    // One-cycle wb_clk_i pulse, rdata valid with it
    logic                              ack;
    logic [turfctl_reg_pkg::DAT_W-1:0] rdata;

    modport host (
        output req,
        output adr,
        output we,
        output wdat,
        input  ack,
        input  rdata
    );

    modport bridge (
        input  req,
        input  adr,
        input  we,
        input  wdat,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

/* domain_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module domain_bridge #(
    parameter type rdata_t = logic [7:0]
) (
    input  logic         wb_clk_i,
    input  logic         wb_rst_i,
    input  logic         far_clk_i,
    input  logic         far_rst_i,
    input  logic         far_ok_i,
    domain_req_if.bridge bus,
    output logic         far_stb_o,
    input  rdata_t       far_rdata_i
);

    logic                              req_q;
    logic                              req_flag;
    logic                              far_stb_q;
    logic                              ret_flag;
    rdata_t                            far_rdata_q;
    logic [turfctl_reg_pkg::DAT_W-1:0] far_rdata_ext;

    // Launch on the rising edge of the held request
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= bus.req;
        end
    end

    assign req_flag = bus.req && !req_q;

    flag_sync u_req_sync (
        .clk_a_i  (wb_clk_i),
        .rst_a_i  (wb_rst_i),
        .flag_a_i (req_flag),
        .clk_b_i  (far_clk_i),
        .rst_b_i  (far_rst_i),
        .flag_b_o (far_stb_o)
    );

    ////////////////////////////////////////////////////////////
    // Far clock domain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge far_clk_i) begin
        if (far_rst_i) begin
            far_stb_q <= 1'b0;
        end else begin
            far_stb_q <= far_stb_o;
        end
    end

    // Sampled with the strobe, static by the time the ack lands
    always_ff @(posedge far_clk_i) begin
        if (far_stb_o) begin
            far_rdata_q <= far_rdata_i;
        end
    end

    flag_sync u_ack_sync (
        .clk_a_i  (far_clk_i),
        .rst_a_i  (far_rst_i),
        .flag_a_i (far_stb_q),
        .clk_b_i  (wb_clk_i),
        .rst_b_i  (wb_rst_i),
        .flag_b_o (ret_flag)
    );

    always_comb begin
        far_rdata_ext = '0;
        far_rdata_ext[$bits(rdata_t)-1:0] = far_rdata_q;
    end

    // Dead far clock finishes at once and reads all ones
    assign bus.ack   = bus.req && (ret_flag || !far_ok_i);
    assign bus.rdata = far_ok_i ? far_rdata_ext : '1;

    a_req_held : assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i) $fell(bus.req) |-> $past(bus.ack)
    );

endmodule

`default_nettype wire

/* phase_shift_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module phase_shift_ctrl #(
    parameter logic [turfctl_phy_pkg::PS_W-1:0] PS_STEPS = turfctl_phy_pkg::PS_STEPS_DEFAULT
) (
    input  logic                             wb_clk_i,
    input  logic                             wb_rst_i,
    input  logic [turfctl_phy_pkg::PS_W-1:0] target_i,
    input  logic                             ps_done_i,
    output logic                             ps_en_o,
    output logic                             busy_o
);

    localparam logic [turfctl_phy_pkg::PS_W-1:0] PS_LAST = PS_STEPS - 1'b1;

    logic [turfctl_phy_pkg::PS_W-1:0] current_q;
    logic                             pending_q;
    logic                             step;

    // One fine step at a time, never while the MMCM is still shifting
    assign step = (current_q != target_i) && !pending_q && !ps_en_o;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            current_q <= '0;
            ps_en_o   <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            ps_en_o <= step;
            // Always walks upward, wrapping at the end of the period
            if (step) begin
                current_q <= (current_q == PS_LAST) ? '0 : current_q + 1'b1;
            end
            if (ps_en_o) begin
                pending_q <= 1'b1;
            end else if (ps_done_i) begin
                pending_q <= 1'b0;
            end
        end
    end

    // A target past PS_LAST is never reached and stays busy
    assign busy_o = (current_q != target_i) || pending_q || ps_en_o;

    a_no_step_pending : assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i) pending_q |-> !ps_en_o
    );

endmodule

`default_nettype wire

/* turfctl_register_core.sv */
`timescale 1ns/1ns
`default_nettype none

module turfctl_register_core #(
    parameter logic [turfctl_phy_pkg::PS_W-1:0] PS_STEPS = turfctl_phy_pkg::PS_STEPS_DEFAULT
) (
    input  logic                                 wb_clk_i,
    input  logic                                 wb_rst_i,
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [turfctl_reg_pkg::ADR_W-1:0]    wb_adr_i,
    input  logic [turfctl_reg_pkg::SEL_W-1:0]    wb_sel_i,
    input  logic [turfctl_reg_pkg::DAT_W-1:0]    wb_dat_i,
    output logic [turfctl_reg_pkg::DAT_W-1:0]    wb_dat_o,
    output logic                                 wb_ack_o,
    input  logic                                 rxclk_i,
    input  logic                                 rxclk_ok_i,
    input  logic                                 sysclk_i,
    input  logic                                 sysclk_ok_i,
    output logic                                 ps_en_o,
    input  logic                                 ps_done_i,
    input  logic                                 mmcm_locked_i,
    output logic                                 mmcm_rst_o,
    output logic                                 idelay_load_o,
    output logic [turfctl_phy_pkg::IDELAY_W-1:0] idelay_value_o,
    input  logic [turfctl_phy_pkg::IDELAY_W-1:0] idelay_current_i,
    output logic                                 iserdes_rst_o,
    output logic                                 iserdes_bitslip_o,
    output logic                                 cin_sync_rst_o,
    output logic                                 cin_sync_capture_o,
    input  logic [turfctl_phy_pkg::CIN_W-1:0]    cin_sync_data_i,
    output logic                                 cin_sync_lock_o,
    input  logic                                 cin_sync_locked_i,
    output logic                                 cout_train_o
);

    turfctl_reg_pkg::wb_state_t        state_q;
    logic                              access;
    logic                              rx_access;
    logic                              sys_access;
    logic [turfctl_reg_pkg::ADR_W-1:0] adr_q;
    logic                              we_q;
    logic [turfctl_reg_pkg::SEL_W-1:0] sel_q;
    logic [turfctl_reg_pkg::DAT_W-1:0] dat_q;
    logic [turfctl_reg_pkg::DAT_W-1:0] rd_q;
    logic [turfctl_reg_pkg::DAT_W-1:0] status;

    // Control register fields
    logic                              mmcm_rst_q;
    logic                              iserdes_rst_q;
    logic                              cin_rst_q;
    logic                              cin_rst_d_q;
    logic                              lock_en_q;
    logic                              cout_train_q;
    logic [turfctl_phy_pkg::PS_W-1:0]  ps_target_q;
    logic                              ps_busy;

    // Far-domain resets and resyncs
    logic [2:0]                        far_rst_cnt_q;
    logic                              far_rst_req;
    logic [1:0]                        rx_rst_sync_q;
    logic [1:0]                        sys_rst_sync_q;
    logic                              rx_rst;
    logic                              sys_rst;
    logic [1:0]                        iserdes_rst_sync_q;
    logic [1:0]                        lock_en_sync_q;
    logic [1:0]                        cin_locked_sync_q;
    logic                              rx_stb;
    logic                              sys_stb;

    domain_req_if rx_req ();
    domain_req_if sys_req ();

    ////////////////////////////////////////////////////////////
    // Wishbone FSM and held access
    ////////////////////////////////////////////////////////////

    assign access     = wb_cyc_i && wb_stb_i;
    // Writes to 0x0C are bitslips in rxclk, reads capture in sysclk
    assign rx_access  = (wb_adr_i == turfctl_reg_pkg::ADR_IDELAY) ||
                        (wb_adr_i == turfctl_reg_pkg::ADR_CIN && wb_we_i);
    assign sys_access = (wb_adr_i == turfctl_reg_pkg::ADR_CIN) && !wb_we_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q <= turfctl_reg_pkg::IDLE;
        end else begin
            case (state_q)
                turfctl_reg_pkg::IDLE: begin
                    if (access && rx_access) begin
                        state_q <= turfctl_reg_pkg::WAIT_RX;
                    end else if (access && sys_access) begin
                        state_q <= turfctl_reg_pkg::WAIT_SYS;
                    end else if (access) begin
                        state_q <= turfctl_reg_pkg::ACK;
                    end
                end
                turfctl_reg_pkg::WAIT_RX: begin
                    if (rx_req.ack) begin
                        state_q <= turfctl_reg_pkg::ACK;
                    end
                end
                turfctl_reg_pkg::WAIT_SYS: begin
                    if (sys_req.ack) begin
                        state_q <= turfctl_reg_pkg::ACK;
                    end
                end
                default: state_q <= turfctl_reg_pkg::IDLE;
            endcase
        end
    end

    // Held steady for the far domains until the FSM returns to IDLE
    always_ff @(posedge wb_clk_i) begin
        if (state_q == turfctl_reg_pkg::IDLE && access) begin
            adr_q <= wb_adr_i;
            we_q  <= wb_we_i;
            sel_q <= wb_sel_i;
            for (int i = 0; i < turfctl_reg_pkg::SEL_W; i++) begin
                if (wb_sel_i[i]) begin
                    dat_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state_q == turfctl_reg_pkg::IDLE && access) begin
            rd_q <= (wb_adr_i == turfctl_reg_pkg::ADR_CTRL) ? status : '0;
        end else if (state_q == turfctl_reg_pkg::WAIT_RX && rx_req.ack) begin
            rd_q <= rx_req.rdata;
        end else if (state_q == turfctl_reg_pkg::WAIT_SYS && sys_req.ack) begin
            rd_q <= sys_req.rdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control/status register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            mmcm_rst_q    <= 1'b0;
            iserdes_rst_q <= 1'b0;
            cin_rst_q     <= 1'b0;
            lock_en_q     <= 1'b0;
            cout_train_q  <= 1'b0;
            ps_target_q   <= '0;
        end else if (wb_ack_o && we_q && adr_q == turfctl_reg_pkg::ADR_CTRL) begin
            if (sel_q[0]) begin
                mmcm_rst_q    <= dat_q[turfctl_reg_pkg::BIT_MMCM_RST];
                iserdes_rst_q <= dat_q[turfctl_reg_pkg::BIT_ISERDES_RST];
                cin_rst_q     <= dat_q[turfctl_reg_pkg::BIT_CIN_RST];
            end
            if (sel_q[1]) begin
                lock_en_q    <= dat_q[turfctl_reg_pkg::BIT_LOCK_EN];
                cout_train_q <= dat_q[turfctl_reg_pkg::BIT_COUT_TRAIN];
            end
            // Phase target straddles bytes 2 and 3
            if (sel_q[2]) begin
                ps_target_q[7:0] <= dat_q[turfctl_reg_pkg::PS_LSB +: 8];
            end
            if (sel_q[3]) begin
                ps_target_q[turfctl_phy_pkg::PS_W-1:8] <=
                    dat_q[turfctl_reg_pkg::PS_LSB + 8 +: turfctl_phy_pkg::PS_W - 8];
            end
        end
    end

    always_comb begin
        status = '0;
        status[turfctl_reg_pkg::BIT_MMCM_RST]    = mmcm_rst_q;
        status[turfctl_reg_pkg::BIT_MMCM_LOCKED] = mmcm_locked_i;
        status[turfctl_reg_pkg::BIT_ISERDES_RST] = iserdes_rst_q;
        status[turfctl_reg_pkg::BIT_CIN_RST]     = cin_rst_q;
        status[turfctl_reg_pkg::BIT_LOCK_EN]     = lock_en_q;
        status[turfctl_reg_pkg::BIT_CIN_LOCKED]  = cin_locked_sync_q[1];
        status[turfctl_reg_pkg::BIT_COUT_TRAIN]  = cout_train_q;
        status[turfctl_reg_pkg::PS_LSB +: turfctl_phy_pkg::PS_W] = ps_target_q;
        status[turfctl_reg_pkg::BIT_PS_BUSY]     = ps_busy;
    end

    phase_shift_ctrl #(
        .PS_STEPS (PS_STEPS)
    ) u_phase (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .target_i  (ps_target_q),
        .ps_done_i (ps_done_i),
        .ps_en_o   (ps_en_o),
        .busy_o    (ps_busy)
    );

    ////////////////////////////////////////////////////////////
    // Clock crossings
    ////////////////////////////////////////////////////////////

    // Stretch reset so sysclk sees it for several of its cycles
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            far_rst_cnt_q <= '0;
        end else if (far_rst_cnt_q != '1) begin
            far_rst_cnt_q <= far_rst_cnt_q + 1'b1;
        end
    end

    assign far_rst_req = wb_rst_i || (far_rst_cnt_q != '1);

    always_ff @(posedge rxclk_i) begin
        rx_rst_sync_q <= {rx_rst_sync_q[0], far_rst_req};
    end

    always_ff @(posedge sysclk_i) begin
        sys_rst_sync_q <= {sys_rst_sync_q[0], far_rst_req};
    end

    assign rx_rst  = rx_rst_sync_q[1];
    assign sys_rst = sys_rst_sync_q[1];

    always_ff @(posedge rxclk_i) begin
        if (rx_rst) begin
            iserdes_rst_sync_q <= '0;
        end else begin
            iserdes_rst_sync_q <= {iserdes_rst_sync_q[0], iserdes_rst_q};
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (sys_rst) begin
            lock_en_sync_q <= '0;
        end else begin
            lock_en_sync_q <= {lock_en_sync_q[0], lock_en_q};
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cin_locked_sync_q <= '0;
            cin_rst_d_q       <= 1'b0;
        end else begin
            cin_locked_sync_q <= {cin_locked_sync_q[0], cin_sync_locked_i};
            cin_rst_d_q       <= cin_rst_q;
        end
    end

    // Parallelizer reset is a single sysclk pulse on the rising edge of the bit
    flag_sync u_cin_rst_sync (
        .clk_a_i  (wb_clk_i),
        .rst_a_i  (wb_rst_i),
        .flag_a_i (cin_rst_q && !cin_rst_d_q),
        .clk_b_i  (sysclk_i),
        .rst_b_i  (sys_rst),
        .flag_b_o (cin_sync_rst_o)
    );

    assign rx_req.req   = (state_q == turfctl_reg_pkg::WAIT_RX);
    assign rx_req.adr   = adr_q;
    assign rx_req.we    = we_q;
    assign rx_req.wdat  = dat_q;
    assign sys_req.req  = (state_q == turfctl_reg_pkg::WAIT_SYS);
    assign sys_req.adr  = adr_q;
    assign sys_req.we   = we_q;
    assign sys_req.wdat = dat_q;

    domain_bridge #(
        .rdata_t (turfctl_phy_pkg::idelay_t)
    ) u_rx_bridge (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .far_clk_i   (rxclk_i),
        .far_rst_i   (rx_rst),
        .far_ok_i    (rxclk_ok_i),
        .bus         (rx_req),
        .far_stb_o   (rx_stb),
        .far_rdata_i (idelay_current_i)
    );

    domain_bridge #(
        .rdata_t (turfctl_phy_pkg::cin_word_t)
    ) u_sys_bridge (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .far_clk_i   (sysclk_i),
        .far_rst_i   (sys_rst),
        .far_ok_i    (sysclk_ok_i),
        .bus         (sys_req),
        .far_stb_o   (sys_stb),
        .far_rdata_i (cin_sync_data_i)
    );

    // Far strobes decoded against the held access
    assign idelay_load_o      = rx_stb && rx_req.we &&
                                rx_req.adr == turfctl_reg_pkg::ADR_IDELAY;
    assign iserdes_bitslip_o  = rx_stb && rx_req.we &&
                                rx_req.adr == turfctl_reg_pkg::ADR_CIN;
    assign cin_sync_capture_o = sys_stb && !sys_req.we &&
                                sys_req.adr == turfctl_reg_pkg::ADR_CIN;
    assign idelay_value_o     = rx_req.wdat[turfctl_phy_pkg::IDELAY_W-1:0];

    assign iserdes_rst_o   = iserdes_rst_sync_q[1];
    assign cin_sync_lock_o = lock_en_sync_q[1];
    assign mmcm_rst_o      = mmcm_rst_q;
    assign cout_train_o    = cout_train_q;
    assign wb_ack_o        = (state_q == turfctl_reg_pkg::ACK);
    assign wb_dat_o        = rd_q;

    a_ack_single : assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i) wb_ack_o |=> !wb_ack_o
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_turfctl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_turfctl;

    localparam int WB_PERIOD   = 100;
    localparam int NUM_ROWS    = 21;
    localparam int WALK_STEPS  = 450;
    localparam int WATCHDOG_NS = (NUM_ROWS * 200 + WALK_STEPS * 8) * WB_PERIOD;
    localparam int ACK_LIMIT   = 64;
    localparam int POLL_LIMIT  = 2000;

    typedef struct packed {
        logic [5:0]  adr;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] wdat;
        logic        rx_ok;
        logic [31:0] exp;
        logic [31:0] mask;
        logic        use_cin;
        logic        wait_idle;
        logic [15:0] n_ps;
        logic [15:0] n_load;
        logic [15:0] n_slip;
        logic [15:0] n_cap;
    } row_t;

    logic        wb_clk_i, wb_rst_i, rxclk_i, sysclk_i;
    logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [5:0]  wb_adr_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_i, wb_dat_o;
    logic        rxclk_ok_i, sysclk_ok_i, ps_en_o, ps_done_i, mmcm_locked_i, mmcm_rst_o;
    logic        idelay_load_o, iserdes_rst_o, iserdes_bitslip_o;
    logic [5:0]  idelay_value_o, idelay_current_i;
    logic        cin_sync_rst_o, cin_sync_capture_o, cin_sync_lock_o, cin_sync_locked_i;
    logic [31:0] cin_sync_data_i;
    logic        cout_train_o;

    logic [2:0]  ps_pipe = '0;
    logic [5:0]  idelay_tap = '0;
    int          ps_count = 0, load_count = 0, slip_count = 0, cap_count = 0;
    int          cin_rst_count = 0;
    int          cin_rst_expect = 0;
    int          errors = 0;
    integer      seed = 32'hada7198e;
    logic [31:0] ctrl_model = '0;
    row_t        rows[$];

    tb_clock_gen #(.PERIOD_NS(100), .RST_CYCLES(2)) u_wb_clk (.clk_o(wb_clk_i), .rst_o(wb_rst_i));
    tb_clock_gen #(.PERIOD_NS(70)) u_rx_clk (.clk_o(rxclk_i), .rst_o());
    tb_clock_gen #(.PERIOD_NS(130)) u_sys_clk (.clk_o(sysclk_i), .rst_o());

    turfctl_register_core DUT (.*);

    ////////////////////////////////////////////////////////////
    // Receiver models
    ////////////////////////////////////////////////////////////

    // MMCM answers each phase step three cycles later
    always @(posedge wb_clk_i) begin
        ps_pipe <= {ps_pipe[1:0], ps_en_o};
        if (ps_en_o) ps_count <= ps_count + 1;
    end
    assign ps_done_i = ps_pipe[2];

    always @(posedge rxclk_i) begin
        if (idelay_load_o) begin
            idelay_tap <= idelay_value_o;
            load_count <= load_count + 1;
        end
        if (iserdes_bitslip_o) slip_count <= slip_count + 1;
    end
    assign idelay_current_i = idelay_tap;

    always @(posedge sysclk_i) begin
        if (cin_sync_capture_o) cap_count <= cap_count + 1;
        if (cin_sync_rst_o) cin_rst_count <= cin_rst_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // Tasks
    ////////////////////////////////////////////////////////////

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input logic [5:0] adr, input int we, input logic [3:0] sel,
                           input logic [31:0] wdat, input int rx_ok, input logic [31:0] exp,
                           input logic [31:0] mask, input int use_cin, input int wait_idle,
                           input int n_ps, input int n_load, input int n_slip, input int n_cap);
        row_t r;
        r = '{adr, we != 0, sel, wdat, rx_ok != 0, exp, mask, use_cin != 0, wait_idle != 0,
              16'(n_ps), 16'(n_load), 16'(n_slip), 16'(n_cap)};
        rows.push_back(r);
    endtask

    // One Wishbone cycle, read data taken while ack is high
    task automatic wb_access(input logic [5:0] adr, input logic we, input logic [3:0] sel,
                             input logic [31:0] dat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_sel_i <= sel;
        wb_dat_i <= dat;
        @(posedge wb_clk_i);
        while (!wb_ack_o && waited < ACK_LIMIT) begin
            @(posedge wb_clk_i);
            waited++;
        end
        rdat = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        if (!wb_ack_o) begin
            $display("No ack for access to address %h at %0t ns", adr, $time);
            errors++;
        end
    endtask

    task automatic wait_phase_idle(input logic [8:0] target);
        logic [31:0] rdat;
        int          polls;
        polls = 0;
        rdat = 32'h8000_0000;
        while (rdat[31] && polls < POLL_LIMIT) begin
            wb_access(6'h00, 1'b0, 4'hF, 32'h0, rdat);
            polls++;
        end
        if (rdat[31]) begin
            $display("Phase walk to %0d did not finish", target);
            errors++;
        end
        check_equal(32'(rdat[24:16]), 32'(target), "phase target after walk");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, run did not end within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rdat;
        logic [31:0] cin_word;
        logic [31:0] expected;
        row_t        r;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_dat_i = '0;
        rxclk_ok_i = 1'b1;
        sysclk_ok_i = 1'b1;
        mmcm_locked_i = 1'b1;
        cin_sync_locked_i = 1'b1;
        cin_sync_data_i = '0;

        // adr, we, sel, wdat, rx_ok, exp, mask, cin, wait, ps, load, slip, cap
        add_row(6'h00, 0, 4'hF, 32'h0, 1, 32'h0000_0202, 32'hFFFF_FFFF, 0, 0, 0, 0, 0, 0);
        add_row(6'h00, 1, 4'h3, 32'h0000_050D, 1, 32'h0, 32'h0, 0, 0, 0, 0, 0, 0);
        add_row(6'h00, 0, 4'hF, 32'h0, 1, 32'h0000_070F, 32'hFFFF_FFFF, 0, 0, 0, 0, 0, 0);
        add_row(6'h00, 1, 4'h3, 32'h0000_FEF0, 1, 32'h0, 32'h0, 0, 0, 0, 0, 0, 0);
        add_row(6'h00, 0, 4'hF, 32'h0, 1, 32'h0000_0602, 32'hFFFF_FFFF, 0, 0, 0, 0, 0, 0);
        // Phase walks 0 to 5, 5 to 447, then across the wrap to 2
        add_row(6'h00, 1, 4'h4, 32'h0005_0000, 1, 32'h0, 32'h0, 0, 0, 0, 0, 0, 0);
        add_row(6'h00, 0, 4'hF, 32'h0, 1, 32'h8005_0000, 32'h81FF_0000, 0, 1, 5, 0, 0, 0);
        add_row(6'h00, 1, 4'hC, 32'h01BF_0000, 1, 32'h0, 32'h0, 0, 0, 0, 0, 0, 0);
        add_row(6'h00, 0, 4'hF, 32'h0, 1, 32'h81BF_0000, 32'h81FF_0000, 0, 1, 447, 0, 0, 0);
        add_row(6'h00, 1, 4'hC, 32'h0002_0000, 1, 32'h0, 32'h0, 0, 0, 0, 0, 0, 0);
        add_row(6'h00, 0, 4'hF, 32'h0, 1, 32'h8002_0000, 32'h81FF_0000, 0, 1, 450, 0, 0, 0);
        add_row(6'h04, 1, 4'hF, 32'h0000_00E7, 1, 32'h0, 32'h0, 0, 0, 0, 1, 0, 0);
        add_row(6'h04, 0, 4'hF, 32'h0, 1, 32'h0000_0027, 32'hFFFF_FFFF, 0, 0, 0, 1, 0, 0);
        add_row(6'h0C, 1, 4'hF, 32'h0, 1, 32'h0, 32'h0, 0, 0, 0, 1, 1, 0);
        add_row(6'h0C, 0, 4'hF, 32'h0, 1, 32'h0, 32'hFFFF_FFFF, 1, 0, 0, 1, 1, 1);
        add_row(6'h0C, 0, 4'hF, 32'h0, 1, 32'h0, 32'hFFFF_FFFF, 1, 0, 0, 1, 1, 2);
        // Dead rxclk, then undecoded addresses
        add_row(6'h04, 0, 4'hF, 32'h0, 0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0, 0, 0, 1, 1, 2);
        add_row(6'h08, 0, 4'hF, 32'h0, 0, 32'h0, 32'hFFFF_FFFF, 0, 0, 0, 1, 1, 2);
        add_row(6'h14, 1, 4'hF, 32'hFFFF_FFFF, 1, 32'h0, 32'h0, 0, 0, 0, 1, 1, 2);
        add_row(6'h04, 0, 4'hF, 32'h0, 1, 32'h0000_0027, 32'hFFFF_FFFF, 0, 0, 0, 1, 1, 2);
        add_row(6'h00, 0, 4'hF, 32'h0, 1, 32'h0002_0602, 32'hFFFF_FFFF, 0, 0, 0, 1, 1, 2);
        check_equal(32'(rows.size()), 32'(NUM_ROWS), "table length");

        while (wb_rst_i) @(posedge wb_clk_i);
        // Let the stretched far-domain resets run out
        repeat (12) @(posedge wb_clk_i);
        check_equal(32'({mmcm_rst_o, cout_train_o, ps_en_o, iserdes_rst_o, cin_sync_lock_o}),
                    32'h0, "control outputs after reset");
        check_equal(32'(ps_count + load_count + slip_count + cap_count + cin_rst_count), 32'h0,
                    "pulses after reset");

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            cin_word = $random(seed);
            @(posedge wb_clk_i);
            rxclk_ok_i      <= r.rx_ok;
            cin_sync_data_i <= cin_word;
            wb_access(r.adr, r.we, r.sel, r.wdat, rdat);
            expected = r.use_cin ? cin_word : r.exp;
            if (r.mask != '0) begin
                check_equal(rdat & r.mask, expected & r.mask, $sformatf("row %0d read data", i));
            end
            if (r.we && r.adr == 6'h00) begin
                // Setting the CIN reset bit gives one parallelizer reset pulse
                if (r.sel[0] && r.wdat[3] && !ctrl_model[3]) begin
                    cin_rst_expect++;
                end
                for (int b = 0; b < 4; b++) begin
                    if (r.sel[b]) ctrl_model[8*b +: 8] = r.wdat[8*b +: 8];
                end
            end
            if (r.wait_idle) begin
                wait_phase_idle(r.exp[24:16]);
                check_equal(32'(ps_count), 32'(r.n_ps), $sformatf("row %0d phase steps", i));
            end
            repeat (6) @(posedge wb_clk_i);
            check_equal(32'(load_count), 32'(r.n_load), $sformatf("row %0d IDELAY loads", i));
            check_equal(32'(slip_count), 32'(r.n_slip), $sformatf("row %0d bitslips", i));
            check_equal(32'(cap_count), 32'(r.n_cap), $sformatf("row %0d captures", i));
            check_equal(32'(mmcm_rst_o), 32'(ctrl_model[0]), $sformatf("row %0d mmcm_rst", i));
            check_equal(32'(cout_train_o), 32'(ctrl_model[10]), $sformatf("row %0d cout", i));
            check_equal(32'(iserdes_rst_o), 32'(ctrl_model[2]),
                        $sformatf("row %0d iserdes_rst", i));
            check_equal(32'(cin_sync_lock_o), 32'(ctrl_model[8]),
                        $sformatf("row %0d cin lock enable", i));
            check_equal(32'(cin_rst_count), 32'(cin_rst_expect),
                        $sformatf("row %0d CIN resets", i));
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
turfctl_reg_pkg.sv
turfctl_phy_pkg.sv
flag_sync.sv
domain_req_if.sv
domain_bridge.sv
phase_shift_ctrl.sv
turfctl_register_core.sv
tb_clock_gen.sv
tb_turfctl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_turfctl -f verilog.f \
    -o tb_turfctl_sim && ./obj_dir/tb_turfctl_sim > sim.log 2>&1
cat sim.log
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
